// ==== files.f ====
+incdir+.
cache_pkg.sv
cache_tag_array.sv
cache_core.sv
mem_arbiter.sv
backing_memory.sv
cache_container.sv
tb_cache_container.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_cache_container -f files.f -o sim_cache
./obj_dir/sim_cache 2>&1 | tee sim.log

if grep -q "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb_cache_checks.svh ====
// reference cache model and checks
`ifndef TB_CACHE_CHECKS_SVH
`define TB_CACHE_CHECKS_SVH

int check_count = 0;
int error_count = 0;

// memory image updated on every data write
word_t ref_mem [MEM_WORDS];
// per cache (0 icache, 1 dcache), per way, per set
logic  m_valid [2][2][SETS];
word_t m_tag   [2][2][SETS];
word_t m_data  [2][2][SETS];
// least recently used way per set
logic  m_lru   [2][SETS];

// power-up memory word
function automatic word_t init_value(input word_t a);
    return a ^ 16'hA5C3;
endfunction

function automatic void model_reset();
    int c;
    int w;
    int s;
    int i;
    for (c = 0; c < 2; c++) begin
        for (s = 0; s < SETS; s++) begin
            m_lru[c][s] = 1'b0;
            for (w = 0; w < 2; w++) begin
                m_valid[c][w][s] = 1'b0;
            end
        end
    end
    for (i = 0; i < MEM_WORDS; i++) begin
        ref_mem[i] = init_value(word_t'(i));
    end
endfunction

// way holding the address or -1 on a miss
function automatic int find_way(input int c, input word_t a);
    int s;
    int w;
    int k;
    s = int'(a) % SETS;
    w = -1;
    for (k = 0; k < 2; k++) begin
        if (m_valid[c][k][s] && (m_tag[c][k][s] == a)) begin
            w = k;
        end
    end
    return w;
endfunction

// expected read data and 1 for a hit
function automatic logic predict_read(input int c, input word_t a, output word_t d);
    int s;
    int w;
    s = int'(a) % SETS;
    w = find_way(c, a);
    if (w >= 0) begin
        d = m_data[c][w][s];
        m_lru[c][s] = (w == 0);
        return 1'b1;
    end
    // empty way first, else lru way
    w = !m_valid[c][0][s] ? 0 : (!m_valid[c][1][s] ? 1 : int'(m_lru[c][s]));
    d = ref_mem[int'(a) % MEM_WORDS];
    m_valid[c][w][s] = 1'b1;
    m_tag[c][w][s]   = a;
    m_data[c][w][s]  = d;
    m_lru[c][s]      = (w == 0);
    return 1'b0;
endfunction

// write-through where a hit updates the line and a miss allocates nothing
function automatic void predict_write(input word_t a, input word_t d);
    int s;
    int w;
    s = int'(a) % SETS;
    w = find_way(1, a);
    if (w >= 0) begin
        m_data[1][w][s] = d;
        m_lru[1][s]     = (w == 0);
    end
    ref_mem[int'(a) % MEM_WORDS] = d;
endfunction

task automatic check_word(input string name, input word_t exp, input word_t got);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAIL %s expected %h got %h", name, exp, got);
    end
endtask

// single status bit such as busy
task automatic check_flag(input string name, input logic exp, input logic got);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAIL %s expected %h got %h", name, exp, got);
    end
endtask

// a hit is a ready one cycle after the request
task automatic check_hit(input string name, input logic exp_hit, input int latency);
    logic got_hit;
    got_hit = (latency == 1);
    check_count++;
    if (got_hit !== exp_hit) begin
        error_count++;
        $display("FAIL %s hit expected %h got %h, latency %0d cycles",
                 name, exp_hit, got_hit, latency);
    end
endtask

`endif

// ==== tb_cache_container.sv ====
// cache subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module tb_cache_container;
    import cache_pkg::*;

    localparam int SETS          = 16;
    localparam int MEM_WORDS     = 1024;
    localparam int MEM_LATENCY   = 4;
    localparam int DRIVE_DLY     = 1;
    localparam int RAND_ACCESSES = 200;
    // 17 directed accesses in tests 1 to 4
    localparam int NUM_ACCESSES    = 17 + RAND_ACCESSES;
    localparam int WATCHDOG_CYCLES = NUM_ACCESSES * (2 * MEM_LATENCY + 8) + 100;

    logic  clk;
    logic  rst_n;
    word_t iaddr;
    logic  iren;
    word_t idata;
    logic  idata_ready;
    logic  ibusy;
    word_t maddr;
    word_t mdata_in;
    logic  mwen;
    logic  mren;
    word_t mdata_out;
    logic  mdata_ready;
    logic  mbusy;

    // latency of the last read per port
    int     last_lat [2];
    int     test_base = 0;
    integer seed = 66;

    `include "tb_cache_checks.svh"

    cache_container #(
        .SETS       (SETS),
        .MEM_WORDS  (MEM_WORDS),
        .MEM_LATENCY(MEM_LATENCY)
    ) dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .iaddr      (iaddr),
        .iren       (iren),
        .idata      (idata),
        .idata_ready(idata_ready),
        .ibusy      (ibusy),
        .maddr      (maddr),
        .mdata_in   (mdata_in),
        .mwen       (mwen),
        .mren       (mren),
        .mdata_out  (mdata_out),
        .mdata_ready(mdata_ready),
        .mbusy      (mbusy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: timeout after %0d cycles, an access never completed", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // port 0 is the instruction side and port 1 the data side
    function automatic logic busy_of(input int port);
        return (port == 0) ? ibusy : mbusy;
    endfunction

    function automatic logic ready_of(input int port);
        return (port == 0) ? idata_ready : mdata_ready;
    endfunction

    // tasks start and end just after a rising edge
    task automatic wait_idle(input int port);
        while (busy_of(port)) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic read_word(input int port, input word_t a);
        word_t exp_data;
        word_t got;
        logic  exp_hit;
        int    lat;
        string data_name;
        string ready_name;
        string busy_name;
        wait_idle(port);
        exp_hit = predict_read(port, a, exp_data);
        if (port == 0) begin
            data_name  = "idata";
            ready_name = "idata_ready";
            busy_name  = "ibusy";
            iaddr      = a;
            iren       = 1'b1;
        end else begin
            data_name  = "mdata_out";
            ready_name = "mdata_ready";
            busy_name  = "mbusy";
            maddr      = a;
            mren       = 1'b1;
        end
        @(posedge clk);
        #DRIVE_DLY;
        // single-cycle request pulse
        if (port == 0) begin
            iren = 1'b0;
        end else begin
            mren = 1'b0;
        end
        lat = 1;
        // busy rises the cycle after a miss and stays low on a hit
        check_flag(busy_name, !exp_hit, busy_of(port));
        while (!ready_of(port)) begin
            @(posedge clk);
            #DRIVE_DLY;
            lat++;
        end
        got = (port == 0) ? idata : mdata_out;
        check_word(data_name, exp_data, got);
        check_hit(ready_name, exp_hit, lat);
        last_lat[port] = lat;
    endtask

    task automatic write_word(input word_t a, input word_t d);
        wait_idle(1);
        predict_write(a, d);
        maddr    = a;
        mdata_in = d;
        mwen     = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        mwen = 1'b0;
        // every write goes to memory so busy rises
        check_flag("mbusy", 1'b1, mbusy);
        while (!mdata_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // read pulse during a data miss that the cache must drop
    task automatic poke_while_busy(input word_t a);
        if (!mbusy) begin
            error_count++;
            $display("ERROR: data port was idle when the ignored request was made");
        end
        maddr = a;
        mren  = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        mren = 1'b0;
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, error_count - test_base);
        test_base = error_count;
    endtask

    initial begin
        integer r;
        word_t  a;
        word_t  d;
        int     n;
        rst_n    = 1'b0;
        iaddr    = '0;
        iren     = 1'b0;
        maddr    = '0;
        mdata_in = '0;
        mwen     = 1'b0;
        mren     = 1'b0;
        model_reset();
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        // cold miss then a one cycle hit
        read_word(0, 16'h0140);
        read_word(0, 16'h0140);
        report_test(1, "cold miss then hit");

        // no allocate on a write miss, update on a write hit
        write_word(16'h0181, 16'h1234);
        read_word(1, 16'h0181);
        write_word(16'h0181, 16'hBEEF);
        read_word(1, 16'h0181);
        // instruction side sees memory after write-through
        read_word(0, 16'h0181);
        report_test(2, "write-through and no allocate");

        // three addresses in set 5
        read_word(1, 16'h0105);
        read_word(1, 16'h0215);
        read_word(1, 16'h0105);
        // evicts 0215 from the lru way
        read_word(1, 16'h0325);
        read_word(1, 16'h0105);
        read_word(1, 16'h0215);
        report_test(3, "lru replacement");

        // both misses in one cycle with the data side winning the arbiter
        fork
            read_word(0, 16'h02C6);
            read_word(1, 16'h03D7);
            begin
                repeat (2) @(posedge clk);
                #DRIVE_DLY;
                poke_while_busy(16'h0178);
            end
        join
        if (last_lat[0] < last_lat[1]) begin
            error_count++;
            $display("ERROR: instruction miss finished before the data miss that won arbitration");
        end
        // dropped request left nothing cached
        read_word(1, 16'h0178);
        report_test(4, "simultaneous misses");

        // random mix over 64 addresses
        for (n = 0; n < RAND_ACCESSES; n++) begin
            r = $random(seed);
            a = word_t'(r & 63);
            d = word_t'($random(seed));
            if (r[8]) begin
                read_word(0, a);
            end else if (r[9]) begin
                write_word(a, d);
            end else begin
                read_word(1, a);
            end
        end
        report_test(5, "random mix");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cache_container.sv ====
// instruction and data cache subsystem
`timescale 1ns/10ps
`default_nettype none

module cache_container #(
    parameter int SETS        = 16,
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 4
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire cache_pkg::word_t iaddr,
    input  wire logic             iren,
    output cache_pkg::word_t      idata,
    output logic                  idata_ready,
    output logic                  ibusy,
    input  wire cache_pkg::word_t maddr,
    input  wire cache_pkg::word_t mdata_in,
    input  wire logic             mwen,
    input  wire logic             mren,
    output cache_pkg::word_t      mdata_out,
    output logic                  mdata_ready,
    output logic                  mbusy
);
    import cache_pkg::*;

    // instruction cache to arbiter
    logic  i_req;
    logic  i_we;
    logic  i_valid;
    word_t i_addr;
    word_t i_wdata;
    word_t i_rdata;

    // data cache to arbiter
    logic  d_req;
    logic  d_we;
    logic  d_valid;
    word_t d_addr;
    word_t d_wdata;
    word_t d_rdata;

    // arbiter to memory
    logic  req;
    logic  we;
    logic  valid;
    word_t addr;
    word_t wdata;
    word_t rdata;

    // instruction side is read only
    cache_core #(
        .SETS(SETS)
    ) icache (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_addr (iaddr),
        .cpu_wdata('0),
        .cpu_rd   (iren),
        .cpu_wr   (1'b0),
        .cpu_rdata(idata),
        .cpu_ready(idata_ready),
        .cpu_busy (ibusy),
        .mem_req  (i_req),
        .mem_we   (i_we),
        .mem_addr (i_addr),
        .mem_wdata(i_wdata),
        .mem_rdata(i_rdata),
        .mem_valid(i_valid)
    );

    cache_core #(
        .SETS(SETS)
    ) dcache (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_addr (maddr),
        .cpu_wdata(mdata_in),
        .cpu_rd   (mren),
        .cpu_wr   (mwen),
        .cpu_rdata(mdata_out),
        .cpu_ready(mdata_ready),
        .cpu_busy (mbusy),
        .mem_req  (d_req),
        .mem_we   (d_we),
        .mem_addr (d_addr),
        .mem_wdata(d_wdata),
        .mem_rdata(d_rdata),
        .mem_valid(d_valid)
    );

    mem_arbiter arbiter (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_req  (i_req),
        .i_we   (i_we),
        .i_addr (i_addr),
        .i_wdata(i_wdata),
        .i_rdata(i_rdata),
        .i_valid(i_valid),
        .d_req  (d_req),
        .d_we   (d_we),
        .d_addr (d_addr),
        .d_wdata(d_wdata),
        .d_rdata(d_rdata),
        .d_valid(d_valid),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .valid  (valid)
    );

    backing_memory #(
        .MEM_WORDS  (MEM_WORDS),
        .MEM_LATENCY(MEM_LATENCY)
    ) memory (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req),
        .we   (we),
        .addr (addr),
        .wdata(wdata),
        .rdata(rdata),
        .valid(valid)
    );

endmodule

`default_nettype wire

// ==== backing_memory.sv ====
// fixed latency word memory
`timescale 1ns/10ps
`default_nettype none

module backing_memory #(
    parameter int MEM_WORDS   = 1024,
    parameter int MEM_LATENCY = 4
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             req,
    input  wire logic             we,
    input  wire cache_pkg::word_t addr,
    input  wire cache_pkg::word_t wdata,
    output cache_pkg::word_t      rdata,
    output logic                  valid
);
    import cache_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(MEM_LATENCY + 1);

    word_t         mem_array [MEM_WORDS];
    logic          busy;
    logic          finish;
    logic [CW-1:0] cnt;
    logic [AW-1:0] word_idx;

    // address wraps at the memory depth
    assign word_idx = AW'(addr % MEM_WORDS);
    // last counted cycle before valid
    assign finish   = busy && (cnt == CW'(MEM_LATENCY - 1));

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_array[i] = mem_init_word(word_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            cnt   <= '0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (finish) begin
                busy  <= 1'b0;
                valid <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end else if (req && !valid) begin
                // req stays high in the valid cycle so no restart then
                busy <= 1'b1;
                cnt  <= CW'(1);
            end
        end
    end

    // access at the end of the latency window
    always_ff @(posedge clk) begin
        if (finish) begin
            rdata <= mem_array[word_idx];
            if (we) begin
                mem_array[word_idx] <= wdata;
            end
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> req);

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
// fixed priority memory arbiter
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             i_req,
    input  wire logic             i_we,
    input  wire cache_pkg::word_t i_addr,
    input  wire cache_pkg::word_t i_wdata,
    output cache_pkg::word_t      i_rdata,
    output logic                  i_valid,
    input  wire logic             d_req,
    input  wire logic             d_we,
    input  wire cache_pkg::word_t d_addr,
    input  wire cache_pkg::word_t d_wdata,
    output cache_pkg::word_t      d_rdata,
    output logic                  d_valid,
    output logic                  req,
    output logic                  we,
    output cache_pkg::word_t      addr,
    output cache_pkg::word_t      wdata,
    input  wire cache_pkg::word_t rdata,
    input  wire logic             valid
);
    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_I,
        GNT_D
    } grant_t;

    grant_t grant;
    grant_t sel;

    // data side wins a tie while idle
    always_comb begin
        sel = grant;
        if (grant == GNT_NONE) begin
            if (d_req) begin
                sel = GNT_D;
            end else if (i_req) begin
                sel = GNT_I;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= GNT_NONE;
        end else if (valid) begin
            grant <= GNT_NONE;
        end else begin
            grant <= sel;
        end
    end

    // mux granted cache onto memory
    assign req   = (sel == GNT_D) ? d_req : ((sel == GNT_I) && i_req);
    assign we    = (sel == GNT_D) ? d_we : i_we;
    assign addr  = (sel == GNT_D) ? d_addr : i_addr;
    assign wdata = (sel == GNT_D) ? d_wdata : i_wdata;

    // response back to the owner only
    assign i_valid = valid && (grant == GNT_I);
    assign d_valid = valid && (grant == GNT_D);
    assign i_rdata = (grant == GNT_I) ? rdata : '0;
    assign d_rdata = (grant == GNT_D) ? rdata : '0;

    a_valid_granted: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> (grant != GNT_NONE));

    // granted cache keeps its request up until the response
    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
        ((grant != GNT_NONE) && !valid) |-> ((grant == GNT_I) ? i_req : d_req));

endmodule

`default_nettype wire

// ==== cache_core.sv ====
// two-way cache controller and data array
`timescale 1ns/10ps
`default_nettype none

module cache_core #(
    parameter int SETS = 16
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire cache_pkg::word_t cpu_addr,
    input  wire cache_pkg::word_t cpu_wdata,
    input  wire logic             cpu_rd,
    input  wire logic             cpu_wr,
    output cache_pkg::word_t      cpu_rdata,
    output logic                  cpu_ready,
    output logic                  cpu_busy,
    output logic                  mem_req,
    output logic                  mem_we,
    output cache_pkg::word_t      mem_addr,
    output cache_pkg::word_t      mem_wdata,
    input  wire cache_pkg::word_t mem_rdata,
    input  wire logic             mem_valid
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    cache_state_t     state;
    word_t            req_addr;
    word_t            req_wdata;
    word_t            fill_data;
    logic             req_wr;
    logic             ready_q;
    logic             hit;
    logic             hit_way;
    logic             victim_way;
    logic             accept;
    logic             rd_hit;
    logic             fill_done;
    logic [IDX_W-1:0] idx;
    word_t            data_mem [2][SETS];

    assign idx       = req_addr[IDX_W-1:0];
    assign fill_done = (state == FILL) && mem_valid;

    // read hit finishes in the lookup cycle itself
    assign rd_hit   = (state == LOOKUP) && !req_wr && hit;
    assign cpu_busy = (state == FILL) || (state == WRITE) || ((state == LOOKUP) && !rd_hit);
    // new request taken in IDLE or back to back after a read hit
    assign accept   = (cpu_rd || cpu_wr) && !cpu_busy;

    assign cpu_ready = rd_hit || ready_q;
    // fill word held for the ready cycle after a miss
    assign cpu_rdata = ready_q ? fill_data : data_mem[hit_way][idx];

    // memory request held until valid
    assign mem_req   = (state == FILL) || (state == WRITE);
    assign mem_we    = (state == WRITE);
    assign mem_addr  = req_addr;
    assign mem_wdata = req_wdata;

    cache_tag_array #(
        .SETS(SETS)
    ) tags (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_addr(req_addr),
        .update     (fill_done),
        .update_way (victim_way),
        .touch      ((state == LOOKUP) && hit),
        .touch_way  (hit_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            req_wr  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    // every write goes through on hit or miss
                    if (req_wr) begin
                        state <= WRITE;
                    end else if (!hit) begin
                        state <= FILL;
                    end else if (!accept) begin
                        state <= IDLE;
                    end
                end
                FILL, WRITE: begin
                    if (mem_valid) begin
                        state   <= IDLE;
                        ready_q <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
            if (accept) begin
                req_wr <= cpu_wr;
            end
        end
    end

    // request capture and data array writes
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= cpu_addr;
            req_wdata <= cpu_wdata;
        end
        if (fill_done) begin
            fill_data                 <= mem_rdata;
            data_mem[victim_way][idx] <= mem_rdata;
        end
        // write hit updates the line and a miss does not allocate
        if ((state == LOOKUP) && req_wr && hit) begin
            data_mem[hit_way][idx] <= req_wdata;
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(cpu_rd && cpu_wr));

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_valid) |=> mem_req && $stable(mem_addr) &&
            $stable(mem_we) && $stable(mem_wdata));

    a_ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_ready |-> !$rose(cpu_busy));

endmodule

`default_nettype wire

// ==== cache_tag_array.sv ====
// two-way tag store with lru
`timescale 1ns/10ps
`default_nettype none

module cache_tag_array #(
    parameter int SETS = 16
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire cache_pkg::word_t lookup_addr,
    input  wire logic            update,
    input  wire logic            update_way,
    input  wire logic            touch,
    input  wire logic            touch_way,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way
);
    import cache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - IDX_W;

    // tag per way and set
    logic [TAG_W-1:0] tag_mem [2][SETS];
    logic [SETS-1:0]  valid_bits [2];
    // lru[set] names the least recently used way
    logic [SETS-1:0]  lru;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             match0;
    logic             match1;
    logic             mru_way;

    assign idx = lookup_addr[IDX_W-1:0];
    assign tag = lookup_addr[ADDR_W-1:IDX_W];

    // combinational compare on both ways
    assign match0 = valid_bits[0][idx] && (tag_mem[0][idx] == tag);
    assign match1 = valid_bits[1][idx] && (tag_mem[1][idx] == tag);
    assign hit     = match0 || match1;
    assign hit_way = match1;

    // empty way first or else the lru way
    assign victim_way = !valid_bits[0][idx] ? 1'b0 :
                        !valid_bits[1][idx] ? 1'b1 : lru[idx];

    // way that becomes most recent this cycle
    assign mru_way = update ? update_way : touch_way;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bits[0] <= '0;
            valid_bits[1] <= '0;
            lru           <= '0;
        end else begin
            if (update) begin
                valid_bits[update_way][idx] <= 1'b1;
            end
            if (update || touch) begin
                lru[idx] <= ~mru_way;
            end
        end
    end

    // tag write on fill
    always_ff @(posedge clk) begin
        if (update) begin
            tag_mem[update_way][idx] <= tag;
        end
    end

    // fill and hit never share a cycle in the controller
    a_no_update_touch: assert property (@(posedge clk) disable iff (!rst_n)
        !(update && touch));

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
// cache subsystem shared definitions
`default_nettype none

package cache_pkg;

    // processor words and addresses are both 16 bits
    localparam int ADDR_W = 16;

    typedef logic [ADDR_W-1:0] word_t;

    // controller states
    // LOOKUP is the tag compare cycle after a request
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        WRITE
    } cache_state_t;

    // power-up contents of backing memory
    // the testbench model uses the same rule
    function automatic word_t mem_init_word(input word_t addr);
        return addr ^ 16'hA5C3;
    endfunction

endpackage

`default_nettype wire
